//--- hw/rvIsaPkg.sv
//////////////////////////////////////////////////////////////////////
// RV64I field widths and major opcodes; no M, Zicsr or FENCE.I
//////////////////////////////////////////////////////////////////////

package rvIsaPkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // Major opcodes, instr[6:0]
    localparam opcode_t OpLui    = 7'b0110111;
    localparam opcode_t OpAuipc  = 7'b0010111;
    localparam opcode_t OpJal    = 7'b1101111;
    localparam opcode_t OpJalr   = 7'b1100111;
    localparam opcode_t OpBranch = 7'b1100011;
    localparam opcode_t OpLoad   = 7'b0000011;
    localparam opcode_t OpStore  = 7'b0100011;
    localparam opcode_t OpImm    = 7'b0010011;
    localparam opcode_t OpReg    = 7'b0110011;
    localparam opcode_t OpImm32  = 7'b0011011;
    localparam opcode_t OpReg32  = 7'b0111011;
    localparam opcode_t OpSystem = 7'b1110011;

    // SYSTEM instr[31:20]
    localparam logic [11:0] Funct12Ecall  = 12'h000;
    localparam logic [11:0] Funct12Ebreak = 12'h001;
    localparam logic [11:0] Funct12Mret   = 12'h302;

endpackage

//--- hw/decodeCtrlPkg.sv
//////////////////////////////////////////////////////////////////////
// Control bundle and handshake payloads of the decode stage
//////////////////////////////////////////////////////////////////////

package decodeCtrlPkg;

    import rvIsaPkg::*;

    typedef logic [4:0] aluOp_t;
    typedef logic [2:0] immSel_t;
    typedef logic [3:0] brType_t;
    typedef logic [2:0] memOp_t;
    typedef logic [1:0] srcBSel_t;

    localparam aluOp_t AluAdd   = 5'd0;
    localparam aluOp_t AluSub   = 5'd1;
    localparam aluOp_t AluSll   = 5'd2;
    localparam aluOp_t AluSlt   = 5'd3;
    localparam aluOp_t AluSltu  = 5'd4;
    localparam aluOp_t AluXor   = 5'd5;
    localparam aluOp_t AluSrl   = 5'd6;
    localparam aluOp_t AluSra   = 5'd7;
    localparam aluOp_t AluOr    = 5'd8;
    localparam aluOp_t AluAnd   = 5'd9;
    localparam aluOp_t AluCopyB = 5'd10;
    localparam aluOp_t AluAddw  = 5'd11;
    localparam aluOp_t AluSubw  = 5'd12;
    localparam aluOp_t AluSllw  = 5'd13;
    localparam aluOp_t AluSrlw  = 5'd14;
    localparam aluOp_t AluSraw  = 5'd15;

    localparam immSel_t ImmI = 3'd0;
    localparam immSel_t ImmS = 3'd1;
    localparam immSel_t ImmB = 3'd2;
    localparam immSel_t ImmU = 3'd3;
    localparam immSel_t ImmJ = 3'd4;

    localparam brType_t BrNone = 4'd0;
    localparam brType_t BrJal  = 4'd1;
    localparam brType_t BrJalr = 4'd2;
    localparam brType_t BrEq   = 4'd3;
    localparam brType_t BrNe   = 4'd4;
    localparam brType_t BrLt   = 4'd5;
    localparam brType_t BrGe   = 4'd6;
    localparam brType_t BrLtu  = 4'd7;
    localparam brType_t BrGeu  = 4'd8;

    // Same encoding as load/store funct3
    localparam memOp_t MemB  = 3'd0;
    localparam memOp_t MemH  = 3'd1;
    localparam memOp_t MemW  = 3'd2;
    localparam memOp_t MemD  = 3'd3;
    localparam memOp_t MemBu = 3'd4;
    localparam memOp_t MemHu = 3'd5;
    localparam memOp_t MemWu = 3'd6;

    localparam logic SrcAPc  = 1'b0;
    localparam logic SrcAReg = 1'b1;

    localparam srcBSel_t SrcBReg  = 2'd0;
    localparam srcBSel_t SrcBImm  = 2'd1;
    localparam srcBSel_t SrcBFour = 2'd2;

    typedef struct packed {
        aluOp_t   aluOp;
        logic     srcASel;
        srcBSel_t srcBSel;
        memOp_t   memOp;
        logic     memWen;
        logic     memToReg;
        logic     regWen;
        brType_t  brType;
        logic     ecall;
        logic     mret;
        logic     ebreak;
        logic     illegal;
    } ctrl_t;

    typedef struct packed {
        instr_t instr;
        xlen_t  pc;
        xlen_t  busA;
        xlen_t  busB;
        xlen_t  mtvec;
        xlen_t  mepc;
    } decodeReq_t;

    typedef struct packed {
        xlen_t   dnpc;
        regIdx_t rd;
        regIdx_t rs1;
        regIdx_t rs2;
        xlen_t   imm;
        ctrl_t   ctrl;
    } decodeRsp_t;

endpackage

//--- hw/immGen.sv
//////////////////////////////////////////////////////////////////////
// Immediate is zero for an unknown format select
//////////////////////////////////////////////////////////////////////

module immGen
    import rvIsaPkg::*;
    import decodeCtrlPkg::*;
(
    input  instr_t  instr_i,
    input  immSel_t immSel_i,
    output xlen_t   imm_o
);

    logic sign;

    assign sign = instr_i[31];

    always_comb begin
        case (immSel_i)
            ImmI: imm_o = {{52{sign}}, instr_i[31:20]};
            ImmS: imm_o = {{52{sign}}, instr_i[31:25], instr_i[11:7]};
            ImmB: begin
                imm_o = {{52{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            end
            // Upper 20 bits, then sign-extended from bit 31
            ImmU: imm_o = {{32{sign}}, instr_i[31:12], 12'b0};
            ImmJ: begin
                imm_o = {{44{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            end
            default: imm_o = '0;
        endcase
    end

endmodule

//--- hw/ctrlDecoder.sv
//////////////////////////////////////////////////////////////////////
// RV64I plus ECALL, EBREAK, MRET; anything else decodes as illegal
//////////////////////////////////////////////////////////////////////

module ctrlDecoder
    import rvIsaPkg::*;
    import decodeCtrlPkg::*;
(
    input  instr_t  instr_i,
    output ctrl_t   ctrl_o,
    output immSel_t immSel_o
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    isImm;
    logic    isWord;
    logic    alt;
    logic    legal;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign isImm  = (opcode == OpImm) || (opcode == OpImm32);
    assign isWord = (opcode == OpImm32) || (opcode == OpReg32);
    // Bit 30 is an immediate bit for everything but the shifts
    assign alt    = instr_i[30] && (!isImm || funct3 == 3'b101);

    function automatic aluOp_t arithOp(input funct3_t f3, input logic sub, input logic word);
        case (f3)
            3'b000:  arithOp = word ? (sub ? AluSubw : AluAddw) : (sub ? AluSub : AluAdd);
            3'b001:  arithOp = word ? AluSllw : AluSll;
            3'b010:  arithOp = AluSlt;
            3'b011:  arithOp = AluSltu;
            3'b100:  arithOp = AluXor;
            3'b101:  arithOp = word ? (sub ? AluSraw : AluSrlw) : (sub ? AluSra : AluSrl);
            3'b110:  arithOp = AluOr;
            default: arithOp = AluAnd;
        endcase
    endfunction

    function automatic logic arithLegal(input funct3_t f3, input funct7_t f7,
                                        input logic imm, input logic word);
        logic    shift;
        funct7_t hi;
        shift = (f3 == 3'b001) || (f3 == 3'b101);
        // 64-bit immediate shifts carry shamt[5] in bit 25
        hi = (imm && !word) ? {f7[6:1], 1'b0} : f7;
        arithLegal = (hi == 7'b0000000) ||
                     (hi == 7'b0100000 && (f3 == 3'b101 || (!imm && f3 == 3'b000)));
        if (imm && !shift) arithLegal = 1'b1;
        if (word && !(shift || f3 == 3'b000)) arithLegal = 1'b0;
    endfunction

    always_comb begin
        ctrl_o         = '0;
        ctrl_o.aluOp   = AluAdd;
        ctrl_o.srcASel = SrcAReg;
        ctrl_o.srcBSel = SrcBReg;
        ctrl_o.brType  = BrNone;
        immSel_o       = ImmI;
        legal          = 1'b1;
        case (opcode)
            OpLui, OpAuipc: begin
                ctrl_o.aluOp   = (opcode == OpLui) ? AluCopyB : AluAdd;
                ctrl_o.srcASel = (opcode == OpLui) ? SrcAReg : SrcAPc;
                ctrl_o.srcBSel = SrcBImm;
                ctrl_o.regWen  = 1'b1;
                immSel_o       = ImmU;
            end
            OpJal, OpJalr: begin
                // Link value pc + 4 goes to rd
                ctrl_o.srcASel = SrcAPc;
                ctrl_o.srcBSel = SrcBFour;
                ctrl_o.regWen  = 1'b1;
                ctrl_o.brType  = (opcode == OpJal) ? BrJal : BrJalr;
                immSel_o       = (opcode == OpJal) ? ImmJ : ImmI;
                legal          = (opcode == OpJal) || (funct3 == 3'b000);
            end
            OpBranch: begin
                immSel_o = ImmB;
                case (funct3[2:1])
                    2'b00:   ctrl_o.aluOp = AluSub;
                    2'b10:   ctrl_o.aluOp = AluSlt;
                    2'b11:   ctrl_o.aluOp = AluSltu;
                    default: legal = 1'b0;
                endcase
                case (funct3)
                    3'b000:  ctrl_o.brType = BrEq;
                    3'b001:  ctrl_o.brType = BrNe;
                    3'b100:  ctrl_o.brType = BrLt;
                    3'b101:  ctrl_o.brType = BrGe;
                    3'b110:  ctrl_o.brType = BrLtu;
                    default: ctrl_o.brType = BrGeu;
                endcase
            end
            OpLoad: begin
                ctrl_o.srcBSel  = SrcBImm;
                ctrl_o.memOp    = funct3;
                ctrl_o.memToReg = 1'b1;
                ctrl_o.regWen   = 1'b1;
                legal = funct3 inside {MemB, MemH, MemW, MemD, MemBu, MemHu, MemWu};
            end
            OpStore: begin
                ctrl_o.srcBSel = SrcBImm;
                ctrl_o.memOp   = funct3;
                ctrl_o.memWen  = 1'b1;
                immSel_o       = ImmS;
                legal          = funct3 inside {MemB, MemH, MemW, MemD};
            end
            OpImm, OpImm32, OpReg, OpReg32: begin
                ctrl_o.aluOp   = arithOp(funct3, alt, isWord);
                ctrl_o.srcBSel = isImm ? SrcBImm : SrcBReg;
                ctrl_o.regWen  = 1'b1;
                legal          = arithLegal(funct3, funct7, isImm, isWord);
            end
            OpSystem: begin
                legal = (instr_i[19:7] == '0);
                case (instr_i[31:20])
                    Funct12Ecall:  ctrl_o.ecall  = 1'b1;
                    Funct12Ebreak: ctrl_o.ebreak = 1'b1;
                    Funct12Mret:   ctrl_o.mret   = 1'b1;
                    default:       legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            ctrl_o         = '0;
            ctrl_o.illegal = 1'b1;
        end
    end

endmodule

//--- hw/branchAlu.sv
//////////////////////////////////////////////////////////////////////
// Compare select uses AluSlt/AluSltu; every other op compares equal
//////////////////////////////////////////////////////////////////////

module branchAlu
    import rvIsaPkg::*;
    import decodeCtrlPkg::*;
(
    input  xlen_t  srcA_i,
    input  xlen_t  srcB_i,
    input  aluOp_t aluOp_i,
    output xlen_t  sum_o,
    output logic   cond_o
);

    logic [64:0] diff;
    logic        lessU;
    logic        lessS;

    assign sum_o = srcA_i + srcB_i;

    // One subtractor serves all three compares
    assign diff  = {1'b0, srcA_i} - {1'b0, srcB_i};
    assign lessU = diff[64];
    assign lessS = (srcA_i[63] != srcB_i[63]) ? srcA_i[63] : diff[63];

    always_comb begin
        case (aluOp_i)
            AluSlt:  cond_o = lessS;
            AluSltu: cond_o = lessU;
            default: cond_o = (diff[63:0] == '0);
        endcase
    end

endmodule

//--- hw/nextPc.sv
//////////////////////////////////////////////////////////////////////
// cond_i means equal / less; NE, GE and GEU take its inverse
//////////////////////////////////////////////////////////////////////

module nextPc
    import rvIsaPkg::*;
    import decodeCtrlPkg::*;
(
    input  brType_t brType_i,
    input  logic    cond_i,
    input  logic    ecall_i,
    input  logic    mret_i,
    input  xlen_t   pc_i,
    input  xlen_t   imm_i,
    input  xlen_t   sum_i,
    input  xlen_t   mtvec_i,
    input  xlen_t   mepc_i,
    output xlen_t   dnpc_o
);

    xlen_t pcPlus4;
    xlen_t pcPlusImm;
    logic  taken;

    assign pcPlus4   = pc_i + 64'd4;
    assign pcPlusImm = pc_i + imm_i;

    always_comb begin
        case (brType_i)
            BrEq, BrLt, BrLtu: taken = cond_i;
            BrNe, BrGe, BrGeu: taken = !cond_i;
            default:           taken = 1'b0;
        endcase
    end

    // Traps first, then returns, then jumps and branches
    always_comb begin
        if (ecall_i) begin
            dnpc_o = mtvec_i;
        end else if (mret_i) begin
            dnpc_o = mepc_i;
        end else if (brType_i == BrJal || taken) begin
            dnpc_o = pcPlusImm;
        end else if (brType_i == BrJalr) begin
            dnpc_o = sum_i;
        end else begin
            dnpc_o = pcPlus4;
        end
    end

    trapExclusive: assert final (!(ecall_i && mret_i))
        else $error("ecall and mret decoded together");

endmodule

//--- hw/instrDecode.sv
//////////////////////////////////////////////////////////////////////
// Purely combinational; dnpc always has bit 0 cleared
//////////////////////////////////////////////////////////////////////

module instrDecode
    import rvIsaPkg::*;
    import decodeCtrlPkg::*;
(
    input  decodeReq_t req_i,
    output decodeRsp_t rsp_o
);

    ctrl_t   ctrl;
    immSel_t immSel;
    xlen_t   imm;
    xlen_t   srcA;
    xlen_t   srcB;
    xlen_t   sum;
    xlen_t   dnpc;
    logic    cond;
    logic    isJalr;

    ctrlDecoder uCtrlDecoder (
        .instr_i  (req_i.instr),
        .ctrl_o   (ctrl),
        .immSel_o (immSel)
    );

    immGen uImmGen (
        .instr_i  (req_i.instr),
        .immSel_i (immSel),
        .imm_o    (imm)
    );

    // JALR target is rs1 + imm rather than the link value
    assign isJalr = (ctrl.brType == BrJalr);
    assign srcA   = (isJalr || ctrl.srcASel == SrcAReg) ? req_i.busA : req_i.pc;

    always_comb begin
        if (isJalr) begin
            srcB = imm;
        end else begin
            case (ctrl.srcBSel)
                SrcBReg:  srcB = req_i.busB;
                SrcBImm:  srcB = imm;
                SrcBFour: srcB = 64'd4;
                default:  srcB = '0;
            endcase
        end
    end

    branchAlu uBranchAlu (
        .srcA_i  (srcA),
        .srcB_i  (srcB),
        .aluOp_i (ctrl.aluOp),
        .sum_o   (sum),
        .cond_o  (cond)
    );

    nextPc uNextPc (
        .brType_i (ctrl.brType),
        .cond_i   (cond),
        .ecall_i  (ctrl.ecall),
        .mret_i   (ctrl.mret),
        .pc_i     (req_i.pc),
        .imm_i    (imm),
        .sum_i    (sum),
        .mtvec_i  (req_i.mtvec),
        .mepc_i   (req_i.mepc),
        .dnpc_o   (dnpc)
    );

    always_comb begin
        rsp_o.dnpc = {dnpc[63:1], 1'b0};
        rsp_o.rd   = req_i.instr[11:7];
        rsp_o.rs1  = req_i.instr[19:15];
        rsp_o.rs2  = req_i.instr[24:20];
        rsp_o.imm  = imm;
        rsp_o.ctrl = ctrl;
    end

endmodule

//--- hw/decodeStage.sv
//////////////////////////////////////////////////////////////////////
// Four-phase req/ack, one request in flight; ack two edges after req
// reqData_i must stay stable while req_i is high
//////////////////////////////////////////////////////////////////////

module decodeStage
    import decodeCtrlPkg::*;
(
    input  logic       clk_i,
    input  logic       arstN_i,
    input  logic       req_i,
    input  decodeReq_t reqData_i,
    output logic       ack_o,
    output decodeRsp_t rsp_o
);

    typedef enum logic [1:0] {
        Idle,
        Eval,
        Ack
    } state_e;

    state_e     stateQ;
    state_e     stateD;
    logic       ackQ;
    decodeReq_t reqQ;
    decodeRsp_t rspD;
    decodeRsp_t rspQ;

    instrDecode uInstrDecode (
        .req_i (reqQ),
        .rsp_o (rspD)
    );

    always_comb begin
        stateD = stateQ;
        case (stateQ)
            Idle:    if (req_i) stateD = Eval;
            Eval:    stateD = Ack;
            // Hold ack until the requester lets go
            Ack:     if (!req_i) stateD = Idle;
            default: stateD = Idle;
        endcase
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            stateQ <= Idle;
            ackQ   <= 1'b0;
        end else begin
            stateQ <= stateD;
            if (stateQ == Eval) begin
                ackQ <= 1'b1;
            end else if (stateQ == Ack && !req_i) begin
                ackQ <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (stateQ == Idle && req_i) begin
            reqQ <= reqData_i;
        end
        if (stateQ == Eval) begin
            rspQ <= rspD;
        end
    end

    assign ack_o = ackQ;
    assign rsp_o = rspQ;

    reqDataStable: assert property (@(posedge clk_i) disable iff (!arstN_i)
        req_i && $past(req_i) |-> $stable(reqData_i))
        else $error("reqData_i changed while req_i was held high");

    reqHeldUntilAck: assert property (@(posedge clk_i) disable iff (!arstN_i)
        req_i && !ack_o |=> req_i)
        else $error("req_i dropped before ack_o was raised");

endmodule

//--- test/decodeRef.svh
//////////////////////////////////////////////////////////////////////
// Expected decode response from RV64I encoding rules
// Illegal encodings keep the opcode's immediate format and go to pc+4
//////////////////////////////////////////////////////////////////////

`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Format follows the opcode alone
function automatic xlen_t refImm(input instr_t i);
    case (i[6:0])
        OpLui, OpAuipc: refImm = $signed({i[31:12], 12'h000});
        OpJal:          refImm = $signed({i[31], i[19:12], i[20], i[30:21], 1'b0});
        OpBranch:       refImm = $signed({i[31], i[7], i[30:25], i[11:8], 1'b0});
        OpStore:        refImm = $signed({i[31:25], i[11:7]});
        default:        refImm = $signed(i[31:20]);
    endcase
endfunction

function automatic aluOp_t refArith(input funct3_t f3, input logic alt, input logic word);
    case (f3)
        3'd0:    refArith = alt ? AluSub : AluAdd;
        3'd1:    refArith = AluSll;
        3'd2:    refArith = AluSlt;
        3'd3:    refArith = AluSltu;
        3'd4:    refArith = AluXor;
        3'd5:    refArith = alt ? AluSra : AluSrl;
        3'd6:    refArith = AluOr;
        default: refArith = AluAnd;
    endcase
    if (word) begin
        case (f3)
            3'd0:    refArith = alt ? AluSubw : AluAddw;
            3'd1:    refArith = AluSllw;
            3'd5:    refArith = alt ? AluSraw : AluSrlw;
            default: ;
        endcase
    end
endfunction

function automatic ctrl_t refCtrl(input instr_t i);
    ctrl_t   c;
    funct3_t f3;
    funct7_t f7;
    logic    ok;
    f3 = i[14:12];
    f7 = i[31:25];
    c = '0;
    c.srcASel = SrcAReg;
    ok = 1'b1;
    case (i[6:0])
        OpLui: begin
            c.aluOp = AluCopyB;
            c.srcBSel = SrcBImm;
            c.regWen = 1'b1;
        end
        OpAuipc: begin
            c.srcASel = SrcAPc;
            c.srcBSel = SrcBImm;
            c.regWen = 1'b1;
        end
        OpJal, OpJalr: begin
            c.srcASel = SrcAPc;
            c.srcBSel = SrcBFour;
            c.regWen = 1'b1;
            c.brType = (i[6:0] == OpJal) ? BrJal : BrJalr;
            ok = (i[6:0] == OpJal) || (f3 == 3'd0);
        end
        OpBranch: begin
            c.aluOp = f3[2] ? (f3[1] ? AluSltu : AluSlt) : AluSub;
            c.brType = f3[2] ? (BrLt + f3[1:0]) : (BrEq + f3[0]);
            ok = (f3[2:1] != 2'b01);
        end
        OpLoad: begin
            c.srcBSel = SrcBImm;
            c.memOp = f3;
            c.memToReg = 1'b1;
            c.regWen = 1'b1;
            ok = (f3 != 3'd7);
        end
        OpStore: begin
            c.srcBSel = SrcBImm;
            c.memOp = f3;
            c.memWen = 1'b1;
            ok = !f3[2];
        end
        OpImm: begin
            c.aluOp = refArith(f3, f3 == 3'd5 && i[30], 1'b0);
            c.srcBSel = SrcBImm;
            c.regWen = 1'b1;
            ok = (f3[1:0] != 2'b01) || (i[31:26] == 6'b0) ||
                 (f3 == 3'd5 && i[31:26] == 6'b010000);
        end
        OpReg: begin
            c.aluOp = refArith(f3, i[30], 1'b0);
            c.regWen = 1'b1;
            ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        end
        OpImm32: begin
            c.aluOp = refArith(f3, f3 == 3'd5 && i[30], 1'b1);
            c.srcBSel = SrcBImm;
            c.regWen = 1'b1;
            ok = (f3 == 3'd0) || (f3 == 3'd1 && f7 == 7'h00) ||
                 (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
        end
        OpReg32: begin
            c.aluOp = refArith(f3, i[30], 1'b1);
            c.regWen = 1'b1;
            ok = (f3 inside {3'd0, 3'd1, 3'd5}) &&
                 (f7 == 7'h00 || (f7 == 7'h20 && f3 != 3'd1));
        end
        OpSystem: begin
            c.ecall = (i[31:20] == Funct12Ecall);
            c.ebreak = (i[31:20] == Funct12Ebreak);
            c.mret = (i[31:20] == Funct12Mret);
            ok = (i[19:7] == '0) && (c.ecall || c.ebreak || c.mret);
        end
        default: ok = 1'b0;
    endcase
    if (!ok) begin
        c = '0;
        c.illegal = 1'b1;
    end
    return c;
endfunction

function automatic decodeRsp_t expectRsp(input decodeReq_t q);
    decodeRsp_t r;
    xlen_t      target;
    logic       taken;
    r.rd = q.instr[11:7];
    r.rs1 = q.instr[19:15];
    r.rs2 = q.instr[24:20];
    r.imm = refImm(q.instr);
    r.ctrl = refCtrl(q.instr);
    case (r.ctrl.brType)
        BrEq:    taken = (q.busA == q.busB);
        BrNe:    taken = (q.busA != q.busB);
        BrLt:    taken = ($signed(q.busA) < $signed(q.busB));
        BrGe:    taken = ($signed(q.busA) >= $signed(q.busB));
        BrLtu:   taken = (q.busA < q.busB);
        BrGeu:   taken = (q.busA >= q.busB);
        BrJal:   taken = 1'b1;
        default: taken = 1'b0;
    endcase
    target = taken ? q.pc + r.imm : q.pc + 64'd4;
    if (r.ctrl.brType == BrJalr) begin
        target = q.busA + r.imm;
    end
    if (r.ctrl.mret) begin
        target = q.mepc;
    end
    if (r.ctrl.ecall) begin
        target = q.mtvec;
    end
    r.dnpc = target & ~64'd1;
    return r;
endfunction

`endif

//--- test/tbDecodeStage.sv
//////////////////////////////////////////////////////////////////////
// Random requests per instruction class; stops at the first mismatch
//////////////////////////////////////////////////////////////////////

module tbDecodeStage
    import rvIsaPkg::*;
    import decodeCtrlPkg::*;
();

    `include "decodeRef.svh"

    localparam int ClkPeriod   = 8;
    localparam int ResetCycles = 16;
    localparam int NumArith    = 60;
    localparam int NumBranch   = 40;
    localparam int NumJump     = 20;
    localparam int NumSystem   = 12;
    localparam int NumIllegal  = 20;
    localparam int NumReq      = NumArith + NumBranch + NumJump + NumSystem + NumIllegal;
    localparam int WatchdogCycles = ResetCycles + NumReq * 40;
    localparam logic [31:0] Seed = 32'he536_14f1;

    logic       clk = 1'b0;
    logic       arstN;
    logic       req;
    decodeReq_t reqData;
    logic       ack;
    decodeRsp_t rsp;
    decodeRsp_t heldRsp;
    logic       ackPrev = 1'b0;
    int         checkedCount = 0;

    decodeStage i_dut (
        .clk_i     (clk),
        .arstN_i   (arstN),
        .req_i     (req),
        .reqData_i (reqData),
        .ack_o     (ack),
        .rsp_o     (rsp)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic checkField(input string name, input logic [63:0] expVal,
                              input logic [63:0] actVal);
        assert (actVal === expVal)
            else abortRun($sformatf("ERROR %0t rsp_o.%s expected %0h actual %0h",
                                    $time, name, expVal, actVal));
    endtask

    function automatic decodeReq_t randomReq(input instr_t i);
        decodeReq_t q;
        q.instr = i;
        q.pc = {$urandom, $urandom};
        q.busA = {$urandom, $urandom};
        q.busB = {$urandom, $urandom};
        q.mtvec = {$urandom, $urandom};
        q.mepc = {$urandom, $urandom};
        return q;
    endfunction

    function automatic instr_t arithInstr();
        opcode_t ops [8];
        instr_t  i;
        ops = '{OpLui, OpAuipc, OpLoad, OpStore, OpImm, OpReg, OpImm32, OpReg32};
        i = $urandom;
        i[6:0] = ops[$urandom_range(7)];
        // Bias funct7 towards legal encodings with bit 30 picking SUB/SRA
        if (i[6:0] inside {OpReg, OpReg32, OpImm32}) begin
            i[31:25] = {1'b0, i[30], 5'b0};
        end else if (i[6:0] == OpImm && i[13:12] == 2'b01) begin
            i[31:26] = {1'b0, i[30], 4'b0};
        end
        return i;
    endfunction

    function automatic instr_t branchInstr();
        funct3_t conds [6];
        instr_t  i;
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        i = $urandom;
        i[6:0] = OpBranch;
        i[14:12] = conds[$urandom_range(5)];
        return i;
    endfunction

    function automatic instr_t jumpInstr(input logic isJalr);
        instr_t i;
        i = $urandom;
        i[6:0] = isJalr ? OpJalr : OpJal;
        if (isJalr) begin
            i[14:12] = 3'd0;
        end
        return i;
    endfunction

    function automatic instr_t systemInstr();
        logic [11:0] f12 [3];
        f12 = '{Funct12Ecall, Funct12Ebreak, Funct12Mret};
        return {f12[$urandom_range(2)], 13'b0, OpSystem};
    endfunction

    function automatic instr_t illegalInstr();
        instr_t i;
        i = $urandom;
        while (i[6:0] inside {OpLui, OpAuipc, OpJal, OpJalr, OpBranch, OpLoad, OpStore,
                              OpImm, OpReg, OpImm32, OpReg32, OpSystem}) begin
            i[6:0] = $urandom_range(127);
        end
        return i;
    endfunction

    // One four-phase transaction with latency checks on both ack edges
    task automatic runRequest(input decodeReq_t q);
        int waitCycles;
        int hold;
        hold = $urandom_range(3);
        @(posedge clk);
        reqData <= q;
        req <= 1'b1;
        @(negedge clk);
        waitCycles = 0;
        while (!ack) begin
            @(negedge clk);
            waitCycles++;
        end
        assert (waitCycles == 2)
            else abortRun($sformatf("ERROR %0t ack_o rise latency expected 2 actual %0d",
                                    $time, waitCycles));
        @(posedge clk);
        repeat (hold) @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        waitCycles = 0;
        while (ack) begin
            @(negedge clk);
            waitCycles++;
        end
        assert (waitCycles == 1)
            else abortRun($sformatf("ERROR %0t ack_o fall latency expected 1 actual %0d",
                                    $time, waitCycles));
    endtask

    // Compare on the ack rise, then hold rsp_o steady while ack stays high
    always @(negedge clk) begin
        decodeRsp_t expRsp;
        expRsp = expectRsp(reqData);
        if (!arstN) begin
            assert (ack === 1'b0)
                else abortRun($sformatf("ERROR %0t ack_o expected 0 actual %b", $time, ack));
        end else if (ack && !ackPrev) begin
            checkField("dnpc", expRsp.dnpc, rsp.dnpc);
            checkField("rd", expRsp.rd, rsp.rd);
            checkField("rs1", expRsp.rs1, rsp.rs1);
            checkField("rs2", expRsp.rs2, rsp.rs2);
            checkField("imm", expRsp.imm, rsp.imm);
            checkField("ctrl.aluOp", expRsp.ctrl.aluOp, rsp.ctrl.aluOp);
            checkField("ctrl.srcASel", expRsp.ctrl.srcASel, rsp.ctrl.srcASel);
            checkField("ctrl.srcBSel", expRsp.ctrl.srcBSel, rsp.ctrl.srcBSel);
            checkField("ctrl.memOp", expRsp.ctrl.memOp, rsp.ctrl.memOp);
            checkField("ctrl.memWen", expRsp.ctrl.memWen, rsp.ctrl.memWen);
            checkField("ctrl.memToReg", expRsp.ctrl.memToReg, rsp.ctrl.memToReg);
            checkField("ctrl.regWen", expRsp.ctrl.regWen, rsp.ctrl.regWen);
            checkField("ctrl.brType", expRsp.ctrl.brType, rsp.ctrl.brType);
            checkField("ctrl.ecall", expRsp.ctrl.ecall, rsp.ctrl.ecall);
            checkField("ctrl.mret", expRsp.ctrl.mret, rsp.ctrl.mret);
            checkField("ctrl.ebreak", expRsp.ctrl.ebreak, rsp.ctrl.ebreak);
            checkField("ctrl.illegal", expRsp.ctrl.illegal, rsp.ctrl.illegal);
            heldRsp = rsp;
            checkedCount++;
        end else if (ack) begin
            assert (rsp === heldRsp)
                else abortRun($sformatf("ERROR %0t rsp_o expected %h actual %h",
                                        $time, heldRsp, rsp));
        end
        ackPrev = ack;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        abortRun("Handshake hang: watchdog expired before all requests completed");
    end

    initial begin
        decodeReq_t q;
        int         n;
        void'($urandom(Seed));
        arstN = 1'b0;
        req = 1'b0;
        reqData = '0;
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
        for (n = 0; n < NumArith; n++) begin
            runRequest(randomReq(arithInstr()));
        end
        // Half the branches see equal operands
        for (n = 0; n < NumBranch; n++) begin
            q = randomReq(branchInstr());
            if ($urandom_range(1) == 1) begin
                q.busB = q.busA;
            end
            runRequest(q);
        end
        for (n = 0; n < NumJump; n++) begin
            runRequest(randomReq(jumpInstr(n[0])));
        end
        for (n = 0; n < NumSystem; n++) begin
            runRequest(randomReq(systemInstr()));
        end
        for (n = 0; n < NumIllegal; n++) begin
            runRequest(randomReq(illegalInstr()));
        end
        repeat (2) @(posedge clk);
        if (checkedCount == NumReq) begin
            $display("Test OK");
            $finish;
        end else begin
            abortRun($sformatf("Only %0d of %0d responses were compared",
                               checkedCount, NumReq));
        end
    end

endmodule

//--- decodeStage.f
+incdir+test
hw/rvIsaPkg.sv
hw/decodeCtrlPkg.sv
hw/immGen.sv
hw/ctrlDecoder.sv
hw/branchAlu.sv
hw/nextPc.sv
hw/instrDecode.sv
hw/decodeStage.sv
test/tbDecodeStage.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - hw/rvIsaPkg.sv
      - hw/decodeCtrlPkg.sv
      - hw/immGen.sv
      - hw/ctrlDecoder.sv
      - hw/branchAlu.sv
      - hw/nextPc.sv
      - hw/instrDecode.sv
      - hw/decodeStage.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tbDecodeStage.sv
